// File: project.f
+incdir+.
decodePkg.sv
opClassifier.sv
fieldExtract.sv
operandFormer.sv
fzDecoder.sv
tbClock.sv
fzDecoderTb.sv

// File: run.sh
#!/bin/sh
# builds the decoder testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module fzDecoderTb -o fzDecoderSim \
	> build.log 2>&1 \
	&& ./obj_dir/fzDecoderSim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// File: tbChecks.svh
// compare tasks and error counters for the decoder testbench
// included inside the testbench module, after the package import
int regErrors = 0;
int immErrors = 0;
int byteErrors = 0;
int flagErrors = 0;
int timeoutErrors = 0;

task automatic checkReg(input string field, input string where, input regId_t got,
	input regId_t want);
	if (got !== want) begin
		regErrors++;
		$display("[ERROR] %s %s: got %h, expected %h", field, where, got, want);
	end
endtask

task automatic checkImm(input string field, input string where, input imm_t got,
	input imm_t want);
	if (got !== want) begin
		immErrors++;
		$display("[ERROR] %s %s: got %h, expected %h", field, where, got, want);
	end
endtask

task automatic checkByte(input string field, input string where, input logic [7:0] got,
	input logic [7:0] want);
	if (got !== want) begin
		byteErrors++;
		$display("[ERROR] %s %s: got %h, expected %h", field, where, got, want);
	end
endtask

task automatic checkFlag(input string field, input string where, input logic got,
	input logic want);
	if (got !== want) begin
		flagErrors++;
		$display("[ERROR] %s %s: got %h, expected %h", field, where, got, want);
	end
endtask

function automatic int errorTotal();
	return regErrors + immErrors + byteErrors + flagErrors + timeoutErrors;
endfunction

// File: fzDecoderTb.sv
// testbench for the Fz block decoder with a table of words applied back to back
// and a block of random register-register words
`timescale 1ns/10ps

module fzDecoderTb;
	import decodePkg::*;

	typedef struct packed {
		istrWord_u word;
		regId_t regN;
		regId_t regM;
		regId_t regO;
		imm_t imm;
		logic [7:0] uCmd;
		logic [7:0] uIxt;
	} row_t;

	logic clock;
	logic reset;
	logic istrValid;
	istrWord_u istrWord;
	logic opValid;
	regId_t regN;
	regId_t regM;
	regId_t regO;
	imm_t imm;
	logic [7:0] uCmd;
	logic [7:0] uIxt;

	row_t rows[$];
	integer seed;

	`include "tbChecks.svh"

	tbClock clockGen (
		.clock(clock),
		.reset(reset)
	);

	fzDecoder dut_i (
		.clock(clock),
		.reset(reset),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.opValid(opValid),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm),
		.uCmd(uCmd),
		.uIxt(uIxt)
	);

	// fields 0, 1 and F land in the special bank unless extended
	function automatic regId_t defaultSelector(input logic [3:0] field, input logic ext);
		regId_t sel;
		sel = {1'b0, ext, field};
		if (!ext && (field == 4'h0 || field == 4'h1 || field == 4'hF))
			sel[5] = 1'b1;
		return sel;
	endfunction

	task automatic addRow(input logic [31:0] word, input regId_t n, input regId_t m,
		input regId_t o, input imm_t value, input logic [7:0] cmd, input logic [7:0] ixt);
		row_t row;
		row.word = word;
		row.regN = n;
		row.regM = m;
		row.regO = o;
		row.imm = value;
		row.uCmd = cmd;
		row.uIxt = ixt;
		rows.push_back(row);
	endtask

	task automatic buildTable();
		// F0 register-register in N M O order
		addRow(32'h1030_F045, 6'h04, 6'h05, 6'h03,
			33'h05, {ccAl, ucAlu3}, {ccAl, ucixAdd});
		addRow(32'h18F3_F0A2, 6'h0A, 6'h02, 6'h2F,
			33'h02, {ccAl, ucAlu3}, {ccAl, ucixAddUl});
		addRow(32'h1012_F067, 6'h06, 6'h07, 6'h21,
			33'h07, {ccAl, ucMul3}, {ccAl, ucixMulS});
		// F0 sub-table in N N M order
		addRow(32'h1019_F00F, 6'h20, 6'h20, 6'h2F,
			33'h0F, {ccAl, ucAlu3}, {ccAl, ucixSub});
		addRow(32'h1C49_F011, 6'h11, 6'h11, 6'h21,
			33'h11, {ccAl, ucAluCmp}, {ccAl, ucixTstQ});
		addRow(32'h12E9_F078, 6'h07, 6'h07, 6'h18,
			33'h18, {ccAl, ucAluCmp}, {ccAl, ucixCmpGt});
		// pc-relative branches
		addRow(32'hC123_F045, grDlr, grPc, grImm,
			33'h0_0004_5123, {ccAl, ucBra}, {ccAl, ucixAdd});
		addRow(32'hD000_F0FF, grDlr, grPc, grImm,
			33'h1_FFFF_F000, {ccAl, ucBsr}, {ccAl, ucixAdd});
		addRow(32'hE7FF_F080, grDlr, grPc, grImm,
			33'h1_FFF8_07FF, {ccCt, ucBra}, {ccCt, ucixAdd});
		addRow(32'hF0AB_F012, grDlr, grPc, grImm,
			33'h0_0001_20AB, {ccCf, ucBra}, {ccCf, ucixAdd});
		// F2 immediate ALU
		addRow(32'h0123_F234, 6'h03, 6'h04, grImm,
			33'h0_0000_0123, {ccAl, ucAlu3}, {ccAl, ucixAdd});
		addRow(32'h10FF_F2F1, 6'h2F, 6'h21, grImm,
			33'h1_FFFF_FEFF, {ccAl, ucAlu3}, {ccAl, ucixAdd});
		addRow(32'h7655_F256, 6'h15, 6'h16, grImm,
			33'h0_0000_0055, {ccAl, ucAlu3}, {ccAl, ucixXor});
		// F8 and F9 with the type picked by imm8 bits 7:5
		addRow(32'h8001_F803, 6'h03, grImm, 6'h03,
			33'h0_0000_8001, {ccAl, ucMovIr}, {ccAl, ucixLdix});
		addRow(32'h1234_F830, 6'h10, grImm, 6'h10,
			33'h1_FFFF_1234, {ccAl, ucMovIr}, {ccAl, ucixLdix});
		addRow(32'hFFF0_F94F, 6'h2F, 6'h2F, grImm,
			33'h1_FFFF_FFF0, {ccAl, ucAlu3}, {ccAl, ucixAdd});
		addRow(32'hABCD_F875, 6'h15, 6'h15, grImm,
			33'h0_0000_ABCD, {ccAl, ucMovIr}, {ccAl, ucixLdiSh16});
		// 24-bit loads
		addRow(32'h5678_FA12, grDlr, grDlr, grImm,
			33'h0_0012_5678, {ccAl, ucMovIr}, {ccAl, ucixLdix});
		addRow(32'h0001_FB80, grDlr, grDlr, grImm,
			33'h1_FF80_0001, {ccAl, ucMovIr}, {ccAl, ucixLdix});
		// bad prefix and then unlisted patterns
		addRow(32'h1030_E045, grZzr, grZzr, grZzr, 33'h0, {ccAl, ucInvop}, 8'h00);
		addRow(32'h1004_F012, grZzr, grZzr, grZzr, 33'h0, {ccAl, ucInvop}, 8'h00);
		addRow(32'h0000_F880, grZzr, grZzr, grZzr, 33'h0, {ccAl, ucInvop}, 8'h00);
		addRow(32'h2000_F000, grZzr, grZzr, grZzr, 33'h0, {ccAl, ucInvop}, 8'h00);
		addRow(32'h0000_F300, grZzr, grZzr, grZzr, 33'h0, {ccAl, ucInvop}, 8'h00);
	endtask

	// F0 ADD words with random register fields and extension bits
	task automatic addRandomRows(input int count);
		istrWord_u word;
		logic [31:0] r;
		int k;
		for (k = 0; k < count; k++) begin
			r = $random(seed);
			word = '0;
			word.regView.major = 4'h1;
			word.regView.exN = r[0];
			word.regView.exM = r[1];
			word.regView.exI = r[2];
			word.regView.fieldO = r[7:4];
			word.regView.prefix = 4'hF;
			word.regView.fieldN = r[11:8];
			word.regView.fieldM = r[15:12];
			addRow(word,
				defaultSelector(word.regView.fieldN, word.regView.exN),
				defaultSelector(word.regView.fieldM, word.regView.exM),
				defaultSelector(word.regView.fieldO, word.regView.exI),
				{28'h0, word[4:0]}, {ccAl, ucAlu3}, {ccAl, ucixAdd});
		end
	endtask

	task automatic checkRow(input int index, input logic wantValid);
		row_t row;
		string where;
		row = rows[index];
		where = $sformatf("row %0d", index);
		checkFlag("opValid", where, opValid, wantValid);
		checkReg("regN", where, regN, row.regN);
		checkReg("regM", where, regM, row.regM);
		checkReg("regO", where, regO, row.regO);
		checkImm("imm", where, imm, row.imm);
		checkByte("uCmd", where, uCmd, row.uCmd);
		checkByte("uIxt", where, uIxt, row.uIxt);
	endtask

	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			#2;
			cycles++;
		end while (reset && cycles < 40);
		if (reset) begin
			timeoutErrors++;
			$display("timeout: reset still asserted after %0d cycles", cycles);
		end
	endtask

	initial begin
		int i;
		istrValid = 1'b0;
		istrWord = '0;
		seed = 32'hdb17_f5fb;
		buildTable();
		addRandomRows(16);
		waitResetRelease();
		if (timeoutErrors == 0) begin
			checkFlag("opValid", "after reset", opValid, 1'b0);
			checkReg("regN", "after reset", regN, grZzr);
			checkReg("regM", "after reset", regM, grZzr);
			checkReg("regO", "after reset", regO, grZzr);
			checkImm("imm", "after reset", imm, 33'h0);
			checkByte("uCmd", "after reset", uCmd, {ccAl, ucInvop});
			for (i = 0; i < rows.size(); i++) begin
				istrValid = 1'b1;
				istrWord = rows[i].word;
				@(posedge clock);
				#2;
				checkRow(i, 1'b1);
			end
			// idle cycle drops opValid while data keeps the last word
			istrValid = 1'b0;
			istrWord = '0;
			@(posedge clock);
			#2;
			checkRow(rows.size() - 1, 1'b0);
		end
		$display("errors: reg %0d, imm %0d, byte %0d, flag %0d, timeout %0d",
			regErrors, immErrors, byteErrors, flagErrors, timeoutErrors);
		if (errorTotal() == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tbClock.sv
// clock and reset source for the decoder testbench
// 20 ns period, reset held high over the first 16 rising edges
`timescale 1ns/10ps

module tbClock (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

// File: fzDecoder.sv
// top level of the Fz block decoder, one word in per cycle
// decoded micro-op appears one clock after a valid word
`timescale 1ns/10ps

module fzDecoder (
	input logic clock,
	input logic reset,
	input logic istrValid,
	input decodePkg::istrWord_u istrWord,
	output logic opValid,
	output decodePkg::regId_t regN,
	output decodePkg::regId_t regM,
	output decodePkg::regId_t regO,
	output decodePkg::imm_t imm,
	output logic [7:0] uCmd,
	output logic [7:0] uIxt
);
	import decodePkg::*;

	nmid_t nmid;
	form_t form;
	ity_t ity;
	ccty_t ccty;
	ucmdIx_t ucmdIx;
	regId_t regNDfl;
	regId_t regMDfl;
	regId_t regODfl;
	regId_t regODf2;
	imm_t immZext17;
	imm_t immNext17;
	imm_t immSext16;
	imm_t immZext16;
	imm_t immNext16;
	imm_t disp20s;
	imm_t imm24Z;
	imm_t imm24N;
	regId_t regNNext;
	regId_t regMNext;
	regId_t regONext;
	imm_t immNext;
	logic [7:0] uCmdNext;
	logic [7:0] uIxtNext;

	opClassifier classifier (
		.word(istrWord),
		.nmid(nmid),
		.form(form),
		.ity(ity),
		.ccty(ccty),
		.ucmdIx(ucmdIx)
	);

	fieldExtract extractor (
		.word(istrWord),
		.regNDfl(regNDfl),
		.regMDfl(regMDfl),
		.regODfl(regODfl),
		.regODf2(regODf2),
		.immZext17(immZext17),
		.immNext17(immNext17),
		.immSext16(immSext16),
		.immZext16(immZext16),
		.immNext16(immNext16),
		.disp20s(disp20s),
		.imm24Z(imm24Z),
		.imm24N(imm24N)
	);

	operandFormer former (
		.nmid(nmid),
		.form(form),
		.ity(ity),
		.ccty(ccty),
		.ucmdIx(ucmdIx),
		.regNDfl(regNDfl),
		.regMDfl(regMDfl),
		.regODfl(regODfl),
		.regODf2(regODf2),
		.immZext17(immZext17),
		.immNext17(immNext17),
		.immSext16(immSext16),
		.immZext16(immZext16),
		.immNext16(immNext16),
		.disp20s(disp20s),
		.imm24Z(imm24Z),
		.imm24N(imm24N),
		.regN(regNNext),
		.regM(regMNext),
		.regO(regONext),
		.imm(immNext),
		.uCmd(uCmdNext),
		.uIxt(uIxtNext)
	);

	// single output stage, data holds while no word arrives
	always_ff @(posedge clock) begin
		if (reset) begin
			opValid <= 1'b0;
			regN <= grZzr;
			regM <= grZzr;
			regO <= grZzr;
			imm <= '0;
			uCmd <= {ccAl, ucInvop};
			uIxt <= 8'h00;
		end else begin
			opValid <= istrValid;
			if (istrValid) begin
				regN <= regNNext;
				regM <= regMNext;
				regO <= regONext;
				imm <= immNext;
				uCmd <= uCmdNext;
				uIxt <= uIxtNext;
			end
		end
	end

endmodule

// File: operandFormer.sv
// selects final registers, immediate and command bytes, combinational
// driven by the classifier results and the extracted fields
`timescale 1ns/10ps

module operandFormer (
	input decodePkg::nmid_t nmid,
	input decodePkg::form_t form,
	input decodePkg::ity_t ity,
	input decodePkg::ccty_t ccty,
	input decodePkg::ucmdIx_t ucmdIx,
	input decodePkg::regId_t regNDfl,
	input decodePkg::regId_t regMDfl,
	input decodePkg::regId_t regODfl,
	input decodePkg::regId_t regODf2,
	input decodePkg::imm_t immZext17,
	input decodePkg::imm_t immNext17,
	input decodePkg::imm_t immSext16,
	input decodePkg::imm_t immZext16,
	input decodePkg::imm_t immNext16,
	input decodePkg::imm_t disp20s,
	input decodePkg::imm_t imm24Z,
	input decodePkg::imm_t imm24N,
	output decodePkg::regId_t regN,
	output decodePkg::regId_t regM,
	output decodePkg::regId_t regO,
	output decodePkg::imm_t imm,
	output logic [7:0] uCmd,
	output logic [7:0] uIxt
);
	import decodePkg::*;

	always_comb begin
		uCmd = {ccty, nmid};
		uIxt = {ccty, ucmdIx};
		regN = grZzr;
		regM = grZzr;
		regO = grZzr;
		imm = '0;

		case (form)
			fmRegReg: begin
				// word bits 4:0 sit at imm24Z[20:16]
				imm = {{(immWidth-5){1'b0}}, imm24Z[20:16]};
				regN = regNDfl;
				case (ity)
					ityUb: begin
						regM = regMDfl;
						regO = regNDfl;
					end
					ityNb: begin
						regM = regNDfl;
						regO = regMDfl;
					end
					default: begin
						regM = regMDfl;
						regO = regODfl;
					end
				endcase
			end
			fmRegImmReg: begin
				regN = regNDfl;
				regM = regMDfl;
				regO = grImm;
				imm = (ity == ityNw) ? immNext17 : immZext17;
			end
			fmImm8Reg: begin
				case (ity)
					itySb, itySw: imm = immSext16;
					ityNb, ityNw: imm = immNext16;
					default: imm = immZext16;
				endcase
				regN = regODf2;
				if ((ity == itySb) || (ity == ityUb) || (ity == ityNb)) begin
					regM = regODf2;
					regO = grImm;
				end else begin
					regM = grImm;
					regO = regODf2;
				end
			end
			fmPcDisp: begin
				regN = grDlr;
				regM = grPc;
				regO = grImm;
				imm = disp20s;
			end
			fmImm12Z, fmImm12N: begin
				regN = grDlr;
				regM = grDlr;
				regO = grImm;
				imm = (form == fmImm12N) ? imm24N : imm24Z;
			end
			default: begin
				// invalid or empty op carries no extension byte
				uIxt = 8'h00;
			end
		endcase
	end

endmodule

// File: fieldExtract.sv
// default register selectors and candidate immediates, combinational
// the operand former picks among these by form and order type
`timescale 1ns/10ps

module fieldExtract (
	input decodePkg::istrWord_u word,
	output decodePkg::regId_t regNDfl,
	output decodePkg::regId_t regMDfl,
	output decodePkg::regId_t regODfl,
	output decodePkg::regId_t regODf2,
	output decodePkg::imm_t immZext17,
	output decodePkg::imm_t immNext17,
	output decodePkg::imm_t immSext16,
	output decodePkg::imm_t immZext16,
	output decodePkg::imm_t immNext16,
	output decodePkg::imm_t disp20s,
	output decodePkg::imm_t imm24Z,
	output decodePkg::imm_t imm24N
);

	// R0, R1 and R15 map to the special bank unless extended
	function automatic logic regSpecial(input logic [3:0] field, input logic ext);
		regSpecial = ((field[3:1] == 3'b000) || (field == 4'hF)) && !ext;
	endfunction

	assign regNDfl = {regSpecial(word.regView.fieldN, word.regView.exN),
		word.regView.exN, word.regView.fieldN};
	assign regMDfl = {regSpecial(word.regView.fieldM, word.regView.exM),
		word.regView.exM, word.regView.fieldM};
	assign regODfl = {regSpecial(word.regView.fieldO, word.regView.exI),
		word.regView.exI, word.regView.fieldO};

	// imm8 forms take the extension bit from word bit 4
	assign regODf2 = {regSpecial(word.regView.fieldM, word.immView.imm8[4]),
		word.immView.imm8[4], word.regView.fieldM};

	// 9-bit immediate from bits 24:16
	assign immZext17 = {24'h000000, word.immView.imm16[8:0]};
	assign immNext17 = {24'hFFFFFF, word.immView.imm16[8:0]};

	assign immSext16 = {{17{word.immView.imm16[15]}}, word.immView.imm16};
	assign immZext16 = {17'h00000, word.immView.imm16};
	assign immNext16 = {17'h1FFFF, word.immView.imm16};

	assign disp20s = {{13{word.immView.imm8[7]}}, word.immView.imm8,
		word.immView.imm16[11:0]};

	assign imm24Z = {9'h000, word.immView.imm8, word.immView.imm16};
	assign imm24N = {9'h1FF, word.immView.imm8, word.immView.imm16};

endmodule

// File: opClassifier.sv
// opcode classifier for the Fz block, combinational
// gives command, operand form, order type, condition and sub-command
`timescale 1ns/10ps

module opClassifier (
	input decodePkg::istrWord_u word,
	output decodePkg::nmid_t nmid,
	output decodePkg::form_t form,
	output decodePkg::ity_t ity,
	output decodePkg::ccty_t ccty,
	output decodePkg::ucmdIx_t ucmdIx
);
	import decodePkg::*;

	always_comb begin
		nmid = ucInvop;
		form = fmZ;
		ity = itySb;
		ccty = ccAl;
		ucmdIx = ucixAdd;

		if (word.regView.prefix == 4'hF) begin
			case (word.regView.block)
				4'h0: begin
					case (word.regView.major)
						4'h1: begin
							nmid = ucAlu3;
							form = fmRegReg;
							case (word.regView.minor)
								4'h0: ucmdIx = ucixAdd;
								4'h1: ucmdIx = ucixSub;
								4'h2: begin
									nmid = ucMul3;
									ucmdIx = ucixMulS;
								end
								4'h3: ucmdIx = word.regView.exQ ? ucixAddUl : ucixAddSl;
								4'h5: ucmdIx = ucixAnd;
								4'h6: ucmdIx = ucixOr;
								4'h7: ucmdIx = ucixXor;
								4'h9: begin
									// sub-table selected by the O field
									ity = ityNb;
									case (word.regView.fieldO)
										4'h0: ucmdIx = ucixAdd;
										4'h1: ucmdIx = ucixSub;
										4'h2: ucmdIx = ucixAdc;
										4'h3: ucmdIx = ucixSbb;
										4'h4: begin
											nmid = ucAluCmp;
											ucmdIx = word.regView.exQ ? ucixTstQ : ucixTst;
										end
										4'h5: ucmdIx = ucixAnd;
										4'h6: ucmdIx = ucixOr;
										4'h7: ucmdIx = ucixXor;
										4'h9: begin
											nmid = ucMul3;
											ucmdIx = ucixMulS;
										end
										4'hC: begin
											nmid = ucAluCmp;
											ucmdIx = word.regView.exQ ? ucixCmpQEq : ucixCmpEq;
										end
										4'hD: begin
											nmid = ucAluCmp;
											ucmdIx = word.regView.exQ ? ucixCmpQHi : ucixCmpHi;
										end
										4'hE: begin
											nmid = ucAluCmp;
											ucmdIx = word.regView.exQ ? ucixCmpQGt : ucixCmpGt;
										end
										4'hF: begin
											nmid = ucMul3;
											ucmdIx = ucixMulU;
										end
										default: nmid = ucInvop;
									endcase
								end
								default: nmid = ucInvop;
							endcase
						end
						4'hC, 4'hD, 4'hE, 4'hF: begin
							// 20-bit pc-relative branches, E and F are conditional
							nmid = (word.regView.major == 4'hD) ? ucBsr : ucBra;
							form = fmPcDisp;
							ity = itySw;
							if (word.regView.major == 4'hE)
								ccty = ccCt;
							else if (word.regView.major == 4'hF)
								ccty = ccCf;
						end
						default: nmid = ucInvop;
					endcase
				end
				4'h2: begin
					nmid = ucAlu3;
					form = fmRegImmReg;
					ity = ityUw;
					case (word.regView.major)
						4'h0: ucmdIx = ucixAdd;
						4'h1: begin
							ity = ityNw;
							ucmdIx = ucixAdd;
						end
						4'h5: ucmdIx = ucixAnd;
						4'h6: ucmdIx = ucixOr;
						4'h7: ucmdIx = ucixXor;
						default: nmid = ucInvop;
					endcase
				end
				4'h8, 4'h9: begin
					nmid = ucMovIr;
					form = fmImm8Reg;
					ucmdIx = ucixLdix;
					case (word.immView.imm8[7:5])
						3'b000: ity = ityUw;
						3'b001: ity = ityNw;
						3'b010: begin
							nmid = ucAlu3;
							ity = itySb;
							ucmdIx = ucixAdd;
						end
						3'b011: begin
							ity = ityUb;
							ucmdIx = ucixLdiSh16;
						end
						default: nmid = ucInvop;
					endcase
				end
				4'hA, 4'hB: begin
					nmid = ucMovIr;
					form = word.regView.block[0] ? fmImm12N : fmImm12Z;
					ucmdIx = ucixLdix;
				end
				default: nmid = ucInvop;
			endcase
		end

		// unmatched patterns fall back to the invalid form
		if (nmid == ucInvop)
			form = fmZ;
	end

endmodule

// File: decodePkg.sv
// shared types, register ids and command codes for the Fz block decoder
// every decoder module and the testbench import this package
package decodePkg;

	localparam int fieldWidth = 4;
	localparam int regIdWidth = 6;
	localparam int immWidth = 33;
	localparam int nmidWidth = 6;
	localparam int formWidth = 5;
	localparam int ityWidth = 4;
	localparam int cctyWidth = 2;
	localparam int ucmdIxWidth = 6;

	// the high halfword is either register fields or a raw 16-bit immediate
	typedef union packed {
		struct packed {
			logic [fieldWidth-1:0] major;
			logic exQ;
			logic exN;
			logic exM;
			logic exI;
			logic [fieldWidth-1:0] fieldO;
			logic [fieldWidth-1:0] minor;
			logic [fieldWidth-1:0] prefix;
			logic [fieldWidth-1:0] block;
			logic [fieldWidth-1:0] fieldN;
			logic [fieldWidth-1:0] fieldM;
		} regView;
		struct packed {
			logic [15:0] imm16;
			logic [fieldWidth-1:0] prefix;
			logic [fieldWidth-1:0] block;
			logic [7:0] imm8;
		} immView;
	} istrWord_u;

	typedef logic [regIdWidth-1:0] regId_t;

	localparam regId_t grDlr = 6'h20;
	localparam regId_t grPc = 6'h38;
	localparam regId_t grImm = 6'h3E;
	localparam regId_t grZzr = 6'h3F;

	typedef logic [immWidth-1:0] imm_t;

	typedef enum logic [nmidWidth-1:0] {
		ucNop = 6'h00,
		ucBra = 6'h02,
		ucBsr = 6'h03,
		ucMovIr = 6'h08,
		ucAlu3 = 6'h10,
		ucAluCmp = 6'h11,
		ucMul3 = 6'h12,
		ucShad3 = 6'h14,
		ucShld3 = 6'h15,
		ucInvop = 6'h3F
	} nmid_t;

	typedef enum logic [formWidth-1:0] {
		fmZ = 5'h00,
		fmRegReg = 5'h01,
		fmRegImmReg = 5'h02,
		fmImm8Reg = 5'h03,
		fmPcDisp = 5'h04,
		fmImm12Z = 5'h05,
		fmImm12N = 5'h06
	} form_t;

	// operand order, the letter gives the immediate extension
	typedef enum logic [ityWidth-1:0] {
		itySb = 4'h0,
		itySw = 4'h1,
		itySq = 4'h3,
		ityUb = 4'h4,
		ityUw = 4'h5,
		ityNb = 4'h8,
		ityNw = 4'h9
	} ity_t;

	typedef enum logic [cctyWidth-1:0] {
		ccAl = 2'd0,
		ccCt = 2'd2,
		ccCf = 2'd3
	} ccty_t;

	typedef enum logic [ucmdIxWidth-1:0] {
		ucixAdd = 6'h00,
		ucixSub = 6'h01,
		ucixAdc = 6'h02,
		ucixSbb = 6'h03,
		ucixTst = 6'h04,
		ucixAnd = 6'h05,
		ucixOr = 6'h06,
		ucixXor = 6'h07,
		ucixAddSl = 6'h08,
		ucixAddUl = 6'h09,
		ucixCmpHs = 6'h0B,
		ucixCmpEq = 6'h0C,
		ucixCmpHi = 6'h0D,
		ucixCmpGt = 6'h0E,
		ucixCmpGe = 6'h0F,
		ucixTstQ = 6'h14,
		ucixCmpQEq = 6'h1C,
		ucixCmpQHi = 6'h1D,
		ucixCmpQGt = 6'h1E,
		ucixMulS = 6'h20,
		ucixMulU = 6'h21,
		ucixLdix = 6'h30,
		ucixLdiSh16 = 6'h31
	} ucmdIx_t;

endpackage
